/* hdl/silencer_cfg.svh */
//------------------------------------------------------------
// Frame depth and stage latencies of the step calculator
// SIL_DIV_LAT must stay equal to the 16-bit dividend width
//------------------------------------------------------------
`ifndef SILENCER_CFG_SVH
`define SILENCER_CFG_SVH

// Transducers per frame
`define SIL_DEPTH 249

// Stage latencies in cycles
`define SIL_DIFF_LAT 3
`define SIL_DIV_LAT 16
`define SIL_RATE_LAT 1

// Sample in to sample out
`define SIL_LATENCY (`SIL_DIFF_LAT + `SIL_DIV_LAT + `SIL_RATE_LAT)

`endif

/* hdl/drive_pkg.sv */
//------------------------------------------------------------
// Drive sample words. Phase comes in as 8 bits and leaves in
// the upper byte of a 16-bit word; a step count of 0 is invalid
//------------------------------------------------------------
`default_nettype none

package drive_pkg;

  // Drive intensity of one transducer
  typedef logic [15:0] intensity_t;

  typedef logic [7:0] phase_t;
  typedef logic [15:0] phase_out_t;  // Phase followed by 8 zero bits

  // Amount the interpolator may move per frame
  typedef logic [15:0] rate_t;

  typedef logic [15:0] steps_t;  // Completion step count

endpackage

`default_nettype wire

/* hdl/step_pkg.sv */
//------------------------------------------------------------
// Frame mode and transducer index of the step calculator
//------------------------------------------------------------
`default_nettype none
`include "silencer_cfg.svh"

package step_pkg;

  // IDLE between frames, one run mode per frame type
  typedef enum logic [1:0] {
    IDLE,
    RUN_FIXED,
    RUN_VARIABLE
  } mode_t;

  typedef logic [$clog2(`SIL_DEPTH)-1:0] idx_t;

endpackage

`default_nettype wire

/* hdl/step_diff.sv */
//------------------------------------------------------------
// Frame control and difference stage with 3 cycles of latency
// A din_valid pulse while a frame is loading is ignored
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "silencer_cfg.svh"

module step_diff (
  input  wire                    CLK,
  input  wire                    rst,
  input  wire                    din_valid,
  input  wire                    fixed_mode,
  input  var drive_pkg::steps_t  steps_intensity,
  input  var drive_pkg::steps_t  steps_phase,
  input  var drive_pkg::rate_t   rate_intensity_fixed,
  input  var drive_pkg::rate_t   rate_phase_fixed,
  input  var drive_pkg::intensity_t intensity_in,
  input  var drive_pkg::phase_t  phase_in,
  output logic                   diff_valid,
  output step_pkg::mode_t        diff_mode,
  output step_pkg::idx_t         diff_index,
  output drive_pkg::intensity_t  diff_intensity,
  output drive_pkg::phase_out_t  diff_phase_folded,
  output drive_pkg::steps_t      div_intensity_steps,
  output drive_pkg::steps_t      div_phase_steps,
  output logic                   diff_new_intensity,
  output logic                   diff_new_phase,
  output drive_pkg::intensity_t  diff_sample_intensity,
  output drive_pkg::phase_t      diff_sample_phase,
  output drive_pkg::rate_t       diff_rate_intensity_fixed,
  output drive_pkg::rate_t       diff_rate_phase_fixed
);

  step_pkg::mode_t mode, s1_mode, s2_mode;
  step_pkg::idx_t in_idx, s1_idx, s2_idx;
  logic [63:0] frame_cfg, s1_cfg, s2_cfg;  // Steps and fixed rates

  drive_pkg::intensity_t tgt_int[`SIL_DEPTH];
  drive_pkg::intensity_t dif_int[`SIL_DEPTH];
  drive_pkg::phase_t tgt_ph[`SIL_DEPTH];
  drive_pkg::phase_t dif_ph[`SIL_DEPTH];
  logic [`SIL_DEPTH-1:0] int_ok, ph_ok;  // Entry written since reset

  drive_pkg::intensity_t s1_int, s1_old_int, s1_dif_int, s2_int, s2_dint, abs_int;
  drive_pkg::phase_t s1_ph, s1_old_ph, s1_dif_ph, s2_ph, s2_dph, abs_ph;
  logic s1_var, int_fresh, ph_fresh, s2_new_int, s2_new_ph;
  logic [7:0] fold;

  assign diff_valid = diff_mode != step_pkg::IDLE;

  assign s1_var = s1_mode == step_pkg::RUN_VARIABLE;
  assign abs_int = (s1_int > s1_old_int) ? s1_int - s1_old_int : s1_old_int - s1_int;
  assign abs_ph = (s1_ph > s1_old_ph) ? s1_ph - s1_old_ph : s1_old_ph - s1_ph;
  assign int_fresh = s1_var && abs_int != '0;
  assign ph_fresh = s1_var && abs_ph != '0;

  // Shorter way round the phase circle
  assign fold = (s2_dph >= 8'd128) ? 8'd0 - s2_dph : s2_dph;

  always_ff @(posedge CLK) begin
    if (rst) begin
      mode <= step_pkg::IDLE;
      in_idx <= '0;
    end else if (mode == step_pkg::IDLE) begin
      if (din_valid) begin
        mode <= fixed_mode ? step_pkg::RUN_FIXED : step_pkg::RUN_VARIABLE;
      end
    end else if (in_idx == step_pkg::idx_t'(`SIL_DEPTH - 1)) begin
      mode <= step_pkg::IDLE;
      in_idx <= '0;
    end else begin
      in_idx <= in_idx + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      s1_mode <= step_pkg::IDLE;
      s2_mode <= step_pkg::IDLE;
      diff_mode <= step_pkg::IDLE;
      int_ok <= '0;
      ph_ok <= '0;
    end else begin
      s1_mode <= mode;  // Mode is a run mode only while samples arrive
      s2_mode <= s1_mode;
      diff_mode <= s2_mode;
      if (int_fresh) int_ok[s1_idx] <= 1'b1;
      if (ph_fresh) ph_ok[s1_idx] <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (din_valid && mode == step_pkg::IDLE) begin
      frame_cfg <= {steps_intensity, steps_phase, rate_intensity_fixed, rate_phase_fixed};
    end

    // Capture sample, read stored target and difference
    s1_idx <= in_idx;
    s1_int <= intensity_in;
    s1_ph <= phase_in;
    s1_cfg <= frame_cfg;
    s1_old_int <= int_ok[in_idx] ? tgt_int[in_idx] : '0;
    s1_dif_int <= int_ok[in_idx] ? dif_int[in_idx] : '0;
    s1_old_ph <= ph_ok[in_idx] ? tgt_ph[in_idx] : '0;
    s1_dif_ph <= ph_ok[in_idx] ? dif_ph[in_idx] : '0;

    // New target replaces the old one only when it moved
    s2_idx <= s1_idx;
    s2_int <= s1_int;
    s2_ph <= s1_ph;
    s2_cfg <= s1_cfg;
    s2_new_int <= int_fresh;
    s2_new_ph <= ph_fresh;
    s2_dint <= int_fresh ? abs_int : s1_dif_int;
    s2_dph <= ph_fresh ? abs_ph : s1_dif_ph;
    if (int_fresh) begin
      tgt_int[s1_idx] <= s1_int;
      dif_int[s1_idx] <= abs_int;
    end
    if (ph_fresh) begin
      tgt_ph[s1_idx] <= s1_ph;
      dif_ph[s1_idx] <= abs_ph;
    end

    diff_index <= s2_idx;
    diff_intensity <= s2_dint;
    diff_phase_folded <= {fold, 8'h00};  // Fold is at most 128
    diff_new_intensity <= s2_new_int;
    diff_new_phase <= s2_new_ph;
    diff_sample_intensity <= s2_int;
    diff_sample_phase <= s2_ph;
    {div_intensity_steps, div_phase_steps, diff_rate_intensity_fixed,
     diff_rate_phase_fixed} <= s2_cfg;
  end

endmodule

`default_nettype wire

/* hdl/step_divider.sv */
//------------------------------------------------------------
// Two-channel pipelined restoring divider, 16 by 16 bits
// Result is undefined for a zero divisor
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "silencer_cfg.svh"

module step_divider #(
  parameter int SIDE_W = 1
) (
  input  wire                CLK,
  input  wire                rst,
  input  wire                in_valid,
  input  var logic [15:0]    dividend_intensity,
  input  var logic [15:0]    dividend_phase,
  input  var logic [15:0]    divisor_intensity,
  input  var logic [15:0]    divisor_phase,
  input  var logic [SIDE_W-1:0] side_in,
  output logic               out_valid,
  output logic [15:0]        quo_intensity,
  output logic [15:0]        rem_intensity,
  output logic [15:0]        quo_phase,
  output logic [15:0]        rem_phase,
  output logic [SIDE_W-1:0]  side_out
);

  localparam int N = `SIL_DIV_LAT;  // One stage per quotient bit

  logic [N-1:0] vld;
  logic [15:0] r_i[N], q_i[N], r_p[N], q_p[N];
  logic [15:0] d_i[N-1], d_p[N-1];  // Last stage needs no divisor copy
  logic [SIDE_W-1:0] side[N];

  // q shifts the dividend out at the top and the quotient in at the bottom
  function automatic logic [31:0] div_step(input logic [15:0] r, q, d);
    logic [16:0] trial;
    trial = {r, q[15]};
    if (trial >= {1'b0, d}) begin
      trial = trial - {1'b0, d};
      return {trial[15:0], q[14:0], 1'b1};
    end
    return {trial[15:0], q[14:0], 1'b0};
  endfunction

  assign out_valid = vld[N-1];
  assign quo_intensity = q_i[N-1];
  assign rem_intensity = r_i[N-1];
  assign quo_phase = q_p[N-1];
  assign rem_phase = r_p[N-1];
  assign side_out = side[N-1];

  always_ff @(posedge CLK) begin
    if (rst) vld <= '0;
    else vld <= {vld[N-2:0], in_valid};
  end

  always_ff @(posedge CLK) begin
    {r_i[0], q_i[0]} <= div_step(16'd0, dividend_intensity, divisor_intensity);
    {r_p[0], q_p[0]} <= div_step(16'd0, dividend_phase, divisor_phase);
    d_i[0] <= divisor_intensity;
    d_p[0] <= divisor_phase;
    side[0] <= side_in;
    for (int s = 1; s < N; s++) begin
      {r_i[s], q_i[s]} <= div_step(r_i[s-1], q_i[s-1], d_i[s-1]);
      {r_p[s], q_p[s]} <= div_step(r_p[s-1], q_p[s-1], d_p[s-1]);
      side[s] <= side[s-1];
    end
    for (int s = 1; s < N - 1; s++) begin
      d_i[s] <= d_i[s-1];
      d_p[s] <= d_p[s-1];
    end
  end

endmodule

`default_nettype wire

/* hdl/step_rate.sv */
//------------------------------------------------------------
// Update rate stage, 1 cycle. The division remainder is spread
// one unit per frame over the frames that follow
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "silencer_cfg.svh"

module step_rate (
  input  wire                    CLK,
  input  wire                    rst,
  input  wire                    in_valid,
  input  var step_pkg::mode_t    in_mode,
  input  var step_pkg::idx_t     in_index,
  input  wire                    in_new_intensity,
  input  wire                    in_new_phase,
  input  var drive_pkg::rate_t   quo_intensity,
  input  var drive_pkg::rate_t   quo_phase,
  input  var logic [15:0]        rem_intensity,
  input  var logic [15:0]        rem_phase,
  input  var drive_pkg::intensity_t in_sample_intensity,
  input  var drive_pkg::phase_t  in_sample_phase,
  input  var drive_pkg::rate_t   rate_intensity_fixed,
  input  var drive_pkg::rate_t   rate_phase_fixed,
  output logic                   dout_valid,
  output drive_pkg::intensity_t  intensity_out,
  output drive_pkg::phase_out_t  phase_out,
  output drive_pkg::rate_t       rate_intensity,
  output drive_pkg::rate_t       rate_phase
);

  logic [15:0] rem_int_mem[`SIL_DEPTH];
  logic [15:0] rem_ph_mem[`SIL_DEPTH];
  logic [`SIL_DEPTH-1:0] rem_ok;  // Both channels are written together
  logic [31:0] step_int, step_ph;  // {rate, remainder left}
  logic run_var;

  // A fresh difference restarts from the divider remainder
  function automatic logic [31:0] spread(input logic fresh,
                                         input logic [15:0] quo, rem, stored);
    logic [15:0] left;
    left = fresh ? rem : stored;
    if (left != 16'd0) return {quo + 16'd1, left - 16'd1};
    return {quo, 16'd0};
  endfunction

  assign run_var = in_valid && in_mode == step_pkg::RUN_VARIABLE;

  always_comb begin
    step_int = spread(in_new_intensity, quo_intensity, rem_intensity,
                      rem_ok[in_index] ? rem_int_mem[in_index] : 16'd0);
    step_ph = spread(in_new_phase, quo_phase, rem_phase,
                     rem_ok[in_index] ? rem_ph_mem[in_index] : 16'd0);
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      dout_valid <= 1'b0;
      rem_ok <= '0;
    end else begin
      dout_valid <= in_valid;
      if (run_var) rem_ok[in_index] <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    intensity_out <= in_sample_intensity;
    phase_out <= {in_sample_phase, 8'h00};
    if (run_var) begin
      rem_int_mem[in_index] <= step_int[15:0];
      rem_ph_mem[in_index] <= step_ph[15:0];
      rate_intensity <= step_int[31:16];
      rate_phase <= step_ph[31:16];
    end else begin
      rate_intensity <= rate_intensity_fixed;  // Fixed mode
      rate_phase <= rate_phase_fixed;
    end
  end

endmodule

`default_nettype wire

/* hdl/silencer_top.sv */
//------------------------------------------------------------
// Silencer step calculator. Samples follow din_valid by one
// cycle; the next pulse may come after the last sample
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module silencer_top (
  input  wire                    CLK,
  input  wire                    rst,
  input  wire                    din_valid,
  input  wire                    fixed_mode,
  input  var drive_pkg::steps_t  steps_intensity,
  input  var drive_pkg::steps_t  steps_phase,
  input  var drive_pkg::rate_t   rate_intensity_fixed,
  input  var drive_pkg::rate_t   rate_phase_fixed,
  input  var drive_pkg::intensity_t intensity_in,
  input  var drive_pkg::phase_t  phase_in,
  output logic                   dout_valid,
  output drive_pkg::intensity_t  intensity_out,
  output drive_pkg::phase_out_t  phase_out,
  output drive_pkg::rate_t       rate_intensity,
  output drive_pkg::rate_t       rate_phase
);

  // Mode, index, new flags, samples and fixed rates ride along the divider
  localparam int SIDE_W = 2 + $bits(step_pkg::idx_t) + 2 + 16 + 8 + 16 + 16;

  logic diff_valid, div_valid;
  step_pkg::mode_t diff_mode;
  logic [1:0] div_mode;
  step_pkg::idx_t diff_index, div_index;
  drive_pkg::intensity_t diff_intensity, diff_sample_intensity, div_sample_intensity;
  drive_pkg::phase_out_t diff_phase_folded;
  drive_pkg::steps_t div_intensity_steps, div_phase_steps;
  logic diff_new_intensity, diff_new_phase, div_new_intensity, div_new_phase;
  drive_pkg::phase_t diff_sample_phase, div_sample_phase;
  drive_pkg::rate_t diff_rate_intensity_fixed, diff_rate_phase_fixed;
  drive_pkg::rate_t div_rate_intensity_fixed, div_rate_phase_fixed;
  drive_pkg::rate_t quo_intensity, quo_phase;
  logic [15:0] rem_intensity, rem_phase;

  step_diff step_diff_inst (
    .CLK(CLK), .rst(rst), .din_valid(din_valid), .fixed_mode(fixed_mode),
    .steps_intensity(steps_intensity), .steps_phase(steps_phase),
    .rate_intensity_fixed(rate_intensity_fixed), .rate_phase_fixed(rate_phase_fixed),
    .intensity_in(intensity_in), .phase_in(phase_in),
    .diff_valid(diff_valid), .diff_mode(diff_mode), .diff_index(diff_index),
    .diff_intensity(diff_intensity), .diff_phase_folded(diff_phase_folded),
    .div_intensity_steps(div_intensity_steps), .div_phase_steps(div_phase_steps),
    .diff_new_intensity(diff_new_intensity), .diff_new_phase(diff_new_phase),
    .diff_sample_intensity(diff_sample_intensity), .diff_sample_phase(diff_sample_phase),
    .diff_rate_intensity_fixed(diff_rate_intensity_fixed),
    .diff_rate_phase_fixed(diff_rate_phase_fixed)
  );

  step_divider #(.SIDE_W(SIDE_W)) step_divider_inst (
    .CLK(CLK), .rst(rst), .in_valid(diff_valid),
    .dividend_intensity(diff_intensity), .dividend_phase(diff_phase_folded),
    .divisor_intensity(div_intensity_steps), .divisor_phase(div_phase_steps),
    .side_in({diff_mode, diff_index, diff_new_intensity, diff_new_phase,
              diff_sample_intensity, diff_sample_phase,
              diff_rate_intensity_fixed, diff_rate_phase_fixed}),
    .out_valid(div_valid),
    .quo_intensity(quo_intensity), .rem_intensity(rem_intensity),
    .quo_phase(quo_phase), .rem_phase(rem_phase),
    .side_out({div_mode, div_index, div_new_intensity, div_new_phase,
               div_sample_intensity, div_sample_phase,
               div_rate_intensity_fixed, div_rate_phase_fixed})
  );

  step_rate step_rate_inst (
    .CLK(CLK), .rst(rst), .in_valid(div_valid),
    .in_mode(step_pkg::mode_t'(div_mode)), .in_index(div_index),
    .in_new_intensity(div_new_intensity), .in_new_phase(div_new_phase),
    .quo_intensity(quo_intensity), .quo_phase(quo_phase),
    .rem_intensity(rem_intensity), .rem_phase(rem_phase),
    .in_sample_intensity(div_sample_intensity), .in_sample_phase(div_sample_phase),
    .rate_intensity_fixed(div_rate_intensity_fixed),
    .rate_phase_fixed(div_rate_phase_fixed),
    .dout_valid(dout_valid), .intensity_out(intensity_out), .phase_out(phase_out),
    .rate_intensity(rate_intensity), .rate_phase(rate_phase)
  );

endmodule

`default_nettype wire

/* tests/tb_silencer_model.svh */
//------------------------------------------------------------
// Reference model of the step calculator, one frame per call
// Reads frame_int and frame_ph of the including testbench
//------------------------------------------------------------
`ifndef TB_SILENCER_MODEL_SVH
`define TB_SILENCER_MODEL_SVH

  // Targets, differences and remainders as the frame rules keep them
  logic [15:0] ref_tgt_int[`SIL_DEPTH];
  logic [15:0] ref_dif_int[`SIL_DEPTH];
  logic [7:0] ref_tgt_ph[`SIL_DEPTH];
  logic [7:0] ref_dif_ph[`SIL_DEPTH];
  logic [15:0] ref_rem_int[`SIL_DEPTH];
  logic [15:0] ref_rem_ph[`SIL_DEPTH];

  logic [63:0] exp_q[$];  // {intensity, phase word, intensity rate, phase rate}

  function automatic void clear_reference();
    for (int k = 0; k < `SIL_DEPTH; k++) begin
      ref_tgt_int[k] = '0;
      ref_dif_int[k] = '0;
      ref_tgt_ph[k] = '0;
      ref_dif_ph[k] = '0;
      ref_rem_int[k] = '0;
      ref_rem_ph[k] = '0;
    end
  endfunction

  function automatic void predict_frame(input logic fixed, input logic [15:0] steps_i,
                                        input logic [15:0] steps_p, input logic [15:0] fix_i,
                                        input logic [15:0] fix_p);
    int now_v, was, dif, turn, dvd, left;
    logic fresh;
    logic [15:0] rate_i, rate_p;
    for (int k = 0; k < `SIL_DEPTH; k++) begin
      rate_i = fix_i;
      rate_p = fix_p;
      if (!fixed) begin
        now_v = int'(frame_int[k]);
        was = int'(ref_tgt_int[k]);
        dif = (now_v > was) ? now_v - was : was - now_v;
        fresh = dif != 0;
        if (fresh) begin
          ref_tgt_int[k] = frame_int[k];
          ref_dif_int[k] = 16'(dif);
        end else begin
          dif = int'(ref_dif_int[k]);  // Unchanged target keeps last difference
        end
        left = fresh ? dif % int'(steps_i) : int'(ref_rem_int[k]);
        rate_i = 16'(dif / int'(steps_i) + ((left != 0) ? 1 : 0));
        ref_rem_int[k] = 16'((left != 0) ? left - 1 : 0);

        now_v = int'(frame_ph[k]);
        was = int'(ref_tgt_ph[k]);
        dif = (now_v > was) ? now_v - was : was - now_v;
        fresh = dif != 0;
        if (fresh) begin
          ref_tgt_ph[k] = frame_ph[k];
          ref_dif_ph[k] = 8'(dif);
        end else begin
          dif = int'(ref_dif_ph[k]);
        end
        // Shorter way round a 256-step circle
        turn = (256 - dif < dif) ? 256 - dif : dif;
        dvd = turn * 256;
        left = fresh ? dvd % int'(steps_p) : int'(ref_rem_ph[k]);
        rate_p = 16'(dvd / int'(steps_p) + ((left != 0) ? 1 : 0));
        ref_rem_ph[k] = 16'((left != 0) ? left - 1 : 0);
      end
      exp_q.push_back({frame_int[k], frame_ph[k], 8'h00, rate_i, rate_p});
    end
  endfunction

`endif

/* tests/tb_silencer.sv */
//------------------------------------------------------------
// Testbench of silencer_top. Outputs are checked at the falling
// edge; frames are sent back to back where a test allows it
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "silencer_cfg.svh"

module tb_silencer;

  localparam int NUM_FRAMES = 16;
  localparam int CYCLE_LIMIT = (NUM_FRAMES + 2) * (`SIL_DEPTH + `SIL_LATENCY + 4);

  logic CLK;
  logic rst;
  logic din_valid;
  logic fixed_mode;
  drive_pkg::steps_t steps_intensity, steps_phase;
  drive_pkg::rate_t rate_intensity_fixed, rate_phase_fixed;
  drive_pkg::intensity_t intensity_in, intensity_out;
  drive_pkg::phase_t phase_in;
  drive_pkg::phase_out_t phase_out;
  drive_pkg::rate_t rate_intensity, rate_phase;
  logic dout_valid;

  drive_pkg::intensity_t frame_int[`SIL_DEPTH];
  drive_pkg::phase_t frame_ph[`SIL_DEPTH];
  int issue_q[$];  // Cycle in which each sample entered
  logic [31:0] lfsr_state = 32'h90239e88;
  int cycle_count = 0;
  int error_count = 0;
  int check_count = 0;
  int tests_run = 0;
  int tests_passed = 0;
  int test_start_errors = 0;
  string test_name;

  `include "tb_silencer_model.svh"

  silencer_top silencer_top_inst (
    .CLK(CLK), .rst(rst), .din_valid(din_valid), .fixed_mode(fixed_mode),
    .steps_intensity(steps_intensity), .steps_phase(steps_phase),
    .rate_intensity_fixed(rate_intensity_fixed), .rate_phase_fixed(rate_phase_fixed),
    .intensity_in(intensity_in), .phase_in(phase_in),
    .dout_valid(dout_valid), .intensity_out(intensity_out), .phase_out(phase_out),
    .rate_intensity(rate_intensity), .rate_phase(rate_phase)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  always @(posedge CLK) cycle_count <= cycle_count + 1;

  initial begin
    while (cycle_count < CYCLE_LIMIT) @(posedge CLK);
    $display("Timeout after %0d cycles with %0d outputs still expected",
             cycle_count, exp_q.size());
    $display("RESULT: FAIL");
    $finish;
  end

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic b;
    v = '0;
    for (int i = 0; i < n; i++) begin
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b) lfsr_state = lfsr_state ^ 32'h80200003;
      v = {v[30:0], b};
    end
    return v;
  endfunction

  function automatic void fill_random();
    for (int k = 0; k < `SIL_DEPTH; k++) begin
      frame_int[k] = (k % 50 == 0) ? 16'd0 : 16'(rand_bits(16));
      frame_ph[k] = 8'(rand_bits(8));
    end
  endfunction

  task automatic send_frame(input logic fixed, input logic [15:0] st_i, input logic [15:0] st_p,
                            input logic [15:0] fix_i, input logic [15:0] fix_p,
                            input int count);
    predict_frame(fixed, st_i, st_p, fix_i, fix_p);
    @(posedge CLK);
    #2;
    din_valid = 1'b1;
    fixed_mode = fixed;
    steps_intensity = st_i;
    steps_phase = st_p;
    rate_intensity_fixed = fix_i;
    rate_phase_fixed = fix_p;
    for (int k = 0; k < count; k++) begin
      @(posedge CLK);
      #2;
      if (k == 0) begin
        din_valid = 1'b0;  // Settings must already be latched
        fixed_mode = ~fixed;
        steps_intensity = 16'(rand_bits(16));
        steps_phase = 16'(rand_bits(16));
        rate_intensity_fixed = 16'(rand_bits(16));
        rate_phase_fixed = 16'(rand_bits(16));
      end
      intensity_in = frame_int[k];
      phase_in = frame_ph[k];
      issue_q.push_back(cycle_count);
    end
  endtask

  task automatic apply_reset();
    @(posedge CLK);
    #2;
    rst = 1'b1;
    din_valid = 1'b0;
    exp_q.delete();
    issue_q.delete();
    clear_reference();
    repeat (3) @(posedge CLK);
    #2;
    rst = 1'b0;
  endtask

  task automatic drain_outputs();
    while (exp_q.size() != 0) @(posedge CLK);
    repeat (2) @(posedge CLK);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_start_errors = error_count;
  endtask

  task automatic report_test();
    tests_run++;
    if (error_count == test_start_errors) begin
      tests_passed++;
      $display("Test %0d %s: passed", tests_run, test_name);
    end else begin
      $display("Test %0d %s: failed with %0d errors", tests_run, test_name,
               error_count - test_start_errors);
    end
  endtask

  // Every valid output cycle is matched against the reference queue
  always @(negedge CLK) begin : compare
    logic [63:0] want;
    int born;
    if (!rst && dout_valid) begin
      check_count++;
      assert (exp_q.size() != 0 && issue_q.size() != 0)
      else begin
        $display("dout_valid high at cycle %0d with no sample outstanding", cycle_count);
        error_count++;
      end
      if (exp_q.size() != 0 && issue_q.size() != 0) begin
        want = exp_q.pop_front();
        born = issue_q.pop_front();
        assert (cycle_count - born == `SIL_LATENCY)
        else begin
          $display("Sample came out %0d cycles after it entered instead of %0d",
                   cycle_count - born, `SIL_LATENCY);
          error_count++;
        end
        assert (intensity_out == want[63:48])
        else begin
          $display("ERROR intensity_out: got %h expected %h", intensity_out, want[63:48]);
          error_count++;
        end
        assert (phase_out == want[47:32])
        else begin
          $display("ERROR phase_out: got %h expected %h", phase_out, want[47:32]);
          error_count++;
        end
        assert (rate_intensity == want[31:16])
        else begin
          $display("ERROR rate_intensity: got %h expected %h", rate_intensity, want[31:16]);
          error_count++;
        end
        assert (rate_phase == want[15:0])
        else begin
          $display("ERROR rate_phase: got %h expected %h", rate_phase, want[15:0]);
          error_count++;
        end
      end
    end
  end

  initial begin
    rst = 1'b1;
    din_valid = 1'b0;
    fixed_mode = 1'b0;
    steps_intensity = 16'd1;
    steps_phase = 16'd1;
    rate_intensity_fixed = '0;
    rate_phase_fixed = '0;
    intensity_in = '0;
    phase_in = '0;
    clear_reference();
    repeat (3) @(posedge CLK);
    #2;
    rst = 1'b0;

    begin_test("fixed mode");
    fill_random();
    send_frame(1'b1, 16'd7, 16'd9, 16'h1234, 16'h00ab, `SIL_DEPTH);
    fill_random();
    send_frame(1'b1, 16'd3, 16'd5, 16'h0042, 16'h0101, `SIL_DEPTH);
    drain_outputs();
    report_test();

    begin_test("variable frame from reset");
    apply_reset();
    fill_random();
    send_frame(1'b0, 16'(rand_bits(8)) + 16'd1, 16'(rand_bits(8)) + 16'd1, '0, '0, `SIL_DEPTH);
    drain_outputs();
    report_test();

    begin_test("repeated frames");
    fill_random();
    repeat (6) send_frame(1'b0, 16'd5, 16'd3, '0, '0, `SIL_DEPTH);
    drain_outputs();
    report_test();

    begin_test("phase fold");
    for (int k = 0; k < `SIL_DEPTH; k++) frame_ph[k] = 8'(rand_bits(6));
    send_frame(1'b0, 16'd4, 16'd6, '0, '0, `SIL_DEPTH);
    // Moves of exactly 128 and of 129 to 255
    for (int k = 0; k < `SIL_DEPTH; k++) begin
      frame_ph[k] = (k % 4 == 0) ? frame_ph[k] + 8'd128 : 8'd192 + 8'(rand_bits(6));
    end
    send_frame(1'b0, 16'd4, 16'd6, '0, '0, `SIL_DEPTH);
    drain_outputs();
    report_test();

    begin_test("fixed frame between variable frames");
    fill_random();
    send_frame(1'b0, 16'd9, 16'd2, '0, '0, `SIL_DEPTH);
    fill_random();
    send_frame(1'b1, 16'd9, 16'd2, 16'h0777, 16'h0333, `SIL_DEPTH);
    send_frame(1'b0, 16'd9, 16'd2, '0, '0, `SIL_DEPTH);  // Same samples as fixed frame
    drain_outputs();
    report_test();

    begin_test("reset mid-frame");
    fill_random();
    send_frame(1'b0, 16'd11, 16'd7, '0, '0, 120);
    apply_reset();
    assert (dout_valid == 1'b0)
    else begin
      $display("ERROR dout_valid: got %h expected 0", dout_valid);
      error_count++;
    end
    send_frame(1'b0, 16'd11, 16'd7, '0, '0, `SIL_DEPTH);
    drain_outputs();
    report_test();

    $display("Tests: %0d run, %0d passed, %0d failed; %0d outputs checked, %0d errors",
             tests_run, tests_passed, tests_run - tests_passed, check_count, error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hdl
+incdir+tests
hdl/drive_pkg.sv
hdl/step_pkg.sv
hdl/step_diff.sv
hdl/step_divider.sv
hdl/step_rate.sv
hdl/silencer_top.sv
tests/tb_silencer.sv

/* run.sh */
#!/bin/sh
# Compile and run the silencer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_silencer -f vlog.f

./obj_dir/Vtb_silencer > sim.log 2>&1
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation finished without failures"
